// File: sim.f
+incdir+test
design/mimo_rx_pkg.sv
design/symbol_buffer.sv
design/rx_csr.sv
design/zf_qpsk_detector.sv
design/mimo_rx_top.sv
test/tb_mimo_rx_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mimo_rx_top
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_model.svh
// Fibonacci LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per returned bit
function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_q = lfsr_step(lfsr_q);
        v      = {v[14:0], lfsr_q[0]};
    end
    return v;
endfunction

// ======================================================================
// APB master doing setup then access with the response sampled mid access cycle
// ======================================================================
task automatic apb_access(input logic wr, input mimo_rx_pkg::apb_addr_t addr,
                          input mimo_rx_pkg::apb_data_t wdata, input logic exp_err,
                          output mimo_rx_pkg::apb_data_t rdata);
    logic err;
    logic rdy;
    i_psel    = 1'b1;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    next_cycle();
    i_penable = 1'b1;
    @(negedge clk);
    rdata     = o_prdata;
    err       = o_pslverr;
    rdy       = o_pready;
    next_cycle();
    i_psel    = 1'b0;
    i_penable = 1'b0;
    assert (rdy === 1'b1) else begin
        $display("Ready was not high in the access cycle of address 0x%0h", addr);
        other_errs++;
    end
    assert (err === exp_err) else begin
        $display("Slave error was %0b on %s of address 0x%0h, should be %0b",
                 err, wr ? "write" : "read", addr, exp_err);
        other_errs++;
    end
endtask

// ZF equalizer and QPSK slicer
// h holds h00_re first in register order and y is {y1_re, y1_im, y2_re, y2_im}
function automatic mimo_rx_pkg::bits_t zf_bits(input logic [127:0] h, input logic [63:0] y);
    longint c [8];
    longint s [4];
    longint x [4];
    mimo_rx_pkg::bits_t b;
    for (int k = 0; k < 8; k++) begin
        c[k] = longint'($signed(h[127-16*k -: 16]));
    end
    for (int k = 0; k < 4; k++) begin
        s[k] = longint'($signed(y[63-16*k -: 16]));
    end
    x[0] = c[0]*s[0] - c[1]*s[1] + c[2]*s[2] - c[3]*s[3];     // x1 re
    x[1] = c[0]*s[1] + c[1]*s[0] + c[2]*s[3] + c[3]*s[2];     // x1 im
    x[2] = c[4]*s[0] - c[5]*s[1] + c[6]*s[2] - c[7]*s[3];     // x2 re
    x[3] = c[4]*s[1] + c[5]*s[0] + c[6]*s[3] + c[7]*s[2];     // x2 im
    for (int k = 0; k < 4; k++) begin
        x[k] = x[k] >>> mimo_rx_pkg::COEF_FRAC;               // Floor like a bit drop
        x[k] = (x[k] > 32767) ? 32767 : ((x[k] < -32768) ? -32768 : x[k]);
        b[k] = (x[k] < 0);
    end
    return b;
endfunction

// File: test/tb_mimo_rx_top.sv
`timescale 1ns/1ps

module tb_mimo_rx_top;

    localparam int NROWS     = 8;
    localparam int CYC_LIMIT = NROWS * 300 + 1000;

    // Inverse channel sets, h00_re first
    localparam logic [127:0] H_ID  = {mimo_rx_pkg::COEF_ONE, 80'd0, mimo_rx_pkg::COEF_ONE, 16'd0};
    localparam logic [127:0] H_MIX = 128'h1800_F400_0A00_0600_FC00_0C00_1C00_E800;
    localparam logic [127:0] H_SAT = 128'h7FFF_7000_8001_6000_7FFF_9000_7FFF_7FFF;

    // ======================================================================
    // Stimulus table
    // ======================================================================
    string        row_name [NROWS] = '{"identity", "identity_gaps", "mixing", "saturation",
                                       "mixing_gaps", "drop_in_replay", "drop_with_gaps",
                                       "after_drop"};
    logic [127:0] row_h    [NROWS] = '{H_ID, H_ID, H_MIX, H_SAT, H_MIX, H_MIX, H_SAT, H_ID};
    logic         row_gap  [NROWS] = '{0, 1, 0, 0, 1, 0, 1, 0};
    logic         row_drop [NROWS] = '{0, 0, 0, 0, 0, 1, 1, 0};

    logic                   clk;
    logic                   rst_n;
    logic                   i_valid, i_symbol_start;
    mimo_rx_pkg::sample_t   i_rx1_re, i_rx1_im, i_rx2_re, i_rx2_im;
    logic                   i_psel, i_penable, i_pwrite;
    mimo_rx_pkg::apb_addr_t i_paddr;
    mimo_rx_pkg::apb_data_t i_pwdata, o_prdata;
    logic                   o_pready, o_pslverr, o_valid;
    mimo_rx_pkg::bits_t     o_rx_bits;

    logic [15:0]            lfsr_q = 16'd35;
    mimo_rx_pkg::bits_t     out_q [$];          // Words seen with o_valid
    int                     cyc = 0;
    int                     first_cyc, last_cyc, accept_cyc;
    int                     value_errs = 0, other_errs = 0, exp_drops = 0;

    mimo_rx_top dut_i (.*);

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    `include "tb_model.svh"

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s expected %0h actual %0h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_reg(input string name, input mimo_rx_pkg::apb_addr_t addr,
                             input logic [31:0] exp);
        mimo_rx_pkg::apb_data_t rd;
        apb_access(1'b0, addr, '0, 1'b0, rd);
        check_val(name, exp, rd);
    endtask

    task automatic run_row(input int r);
        logic [63:0]            ys [mimo_rx_pkg::SYM_LEN];
        mimo_rx_pkg::bits_t     exp_q [$];
        mimo_rx_pkg::apb_data_t rd;
        int                     waited;
        for (int k = 0; k < 8; k++) begin
            apb_access(1'b1, mimo_rx_pkg::apb_addr_t'(4 * k), {16'd0, row_h[r][127-16*k -: 16]},
                       1'b0, rd);
        end
        for (int i = 0; i < mimo_rx_pkg::SYM_LEN; i++) begin
            ys[i][63:48] = take_bits(16);
            ys[i][47:32] = take_bits(16);
            ys[i][31:16] = take_bits(16);
            ys[i][15:0]  = take_bits(16);
            if (i >= mimo_rx_pkg::NCP) begin
                exp_q.push_back(zf_bits(row_h[r], ys[i]));  // CP samples give no output
            end
        end
        out_q.delete();
        for (int i = 0; i < mimo_rx_pkg::SYM_LEN; i++) begin
            if (row_gap[r] && take_bits(1) != 0) begin
                i_valid = 1'b0;
                next_cycle();
            end
            i_valid        = 1'b1;
            i_symbol_start = (i == 0);
            {i_rx1_re, i_rx1_im, i_rx2_re, i_rx2_im} = ys[i];
            next_cycle();
        end
        accept_cyc     = cyc;                   // Just past the edge taking sample 79
        i_valid        = 1'b0;
        i_symbol_start = 1'b0;
        if (row_drop[r]) begin
            repeat (10) next_cycle();
            i_valid        = 1'b1;              // Start lands inside the replay
            i_symbol_start = 1'b1;
            next_cycle();
            i_valid        = 1'b0;
            i_symbol_start = 1'b0;
            exp_drops++;
        end
        waited = 0;
        while (out_q.size() < mimo_rx_pkg::NFFT && waited < 200) begin
            next_cycle();
            waited++;
        end
        repeat (20) next_cycle();               // Room for stray extra words
        assert (out_q.size() == mimo_rx_pkg::NFFT) else begin
            $display("%s: %0d output words arrived instead of %0d",
                     row_name[r], out_q.size(), mimo_rx_pkg::NFFT);
            other_errs++;
        end
        if (out_q.size() == mimo_rx_pkg::NFFT) begin
            check_val({row_name[r], " latency"}, 32'd5, 32'(first_cyc - accept_cyc));
            check_val({row_name[r], " burst span"}, 32'(mimo_rx_pkg::NFFT - 1),
                      32'(last_cyc - first_cyc));
        end
        for (int i = 0; i < out_q.size() && i < exp_q.size(); i++) begin
            check_val($sformatf("%s word %0d", row_name[r], i), 32'(exp_q[i]), 32'(out_q[i]));
        end
        check_reg({row_name[r], " drop count"}, mimo_rx_pkg::REG_DROP_CNT, 32'(exp_drops));
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Output capture, sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n && o_valid) begin
            if (out_q.size() == 0) begin
                first_cyc = cyc;
            end
            last_cyc = cyc;
            out_q.push_back(o_rx_bits);
        end
    end

    initial begin
        while (cyc < CYC_LIMIT) @(posedge clk);
        $display("Timeout: no result after %0d clock cycles", CYC_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        mimo_rx_pkg::apb_data_t rd;
        rst_n = 1'b0;
        {i_valid, i_symbol_start, i_psel, i_penable, i_pwrite} = '0;
        {i_rx1_re, i_rx1_im, i_rx2_re, i_rx2_im} = '0;
        i_paddr  = '0;
        i_pwdata = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        // ==================================================================
        // Reset values and register access
        // ==================================================================
        check_val("reset o_valid", 32'd0, 32'(o_valid));
        check_val("reset o_pslverr", 32'd0, 32'(o_pslverr));
        for (int k = 0; k < 8; k++) begin
            check_reg($sformatf("reset coef 0x%0h", 4 * k), mimo_rx_pkg::apb_addr_t'(4 * k),
                      (k == 0 || k == 6) ? 32'(mimo_rx_pkg::COEF_ONE) : 32'd0);
        end
        check_reg("reset drop count", mimo_rx_pkg::REG_DROP_CNT, 32'd0);
        apb_access(1'b1, mimo_rx_pkg::REG_H01_IM, 32'hABCD_8123, 1'b0, rd);
        check_reg("negative coef readback", mimo_rx_pkg::REG_H01_IM, 32'hFFFF_8123);
        apb_access(1'b1, mimo_rx_pkg::REG_H10_RE, 32'hFFFF_1234, 1'b0, rd);
        check_reg("positive coef readback", mimo_rx_pkg::REG_H10_RE, 32'h0000_1234);
        apb_access(1'b0, 8'h24, '0, 1'b1, rd);                            // Past the map
        apb_access(1'b1, mimo_rx_pkg::REG_DROP_CNT, 32'h5A, 1'b1, rd);   // Read only
        check_reg("drop count after write", mimo_rx_pkg::REG_DROP_CNT, 32'd0);

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: design/mimo_rx_top.sv
`timescale 1ns/1ps

module mimo_rx_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // Symbol-aligned samples, two antennas
    input  logic                   i_valid,
    input  logic                   i_symbol_start,
    input  mimo_rx_pkg::sample_t   i_rx1_re,
    input  mimo_rx_pkg::sample_t   i_rx1_im,
    input  mimo_rx_pkg::sample_t   i_rx2_re,
    input  mimo_rx_pkg::sample_t   i_rx2_im,

    // APB
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  mimo_rx_pkg::apb_addr_t i_paddr,
    input  mimo_rx_pkg::apb_data_t i_pwdata,
    output mimo_rx_pkg::apb_data_t o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,

    output logic                   o_valid,
    output mimo_rx_pkg::bits_t     o_rx_bits
);

    logic                 buf_valid;
    logic                 buf_drop;
    mimo_rx_pkg::sample_t buf_rx1_re, buf_rx1_im;
    mimo_rx_pkg::sample_t buf_rx2_re, buf_rx2_im;

    mimo_rx_pkg::coef_t   h00_re, h00_im, h01_re, h01_im;
    mimo_rx_pkg::coef_t   h10_re, h10_im, h11_re, h11_im;

    // ======================================================================
    // CP removal buffer
    // ======================================================================
    symbol_buffer u_buf (
        .clk(clk), .rst_n(rst_n),
        .i_valid(i_valid), .i_symbol_start(i_symbol_start),
        .i_rx1_re(i_rx1_re), .i_rx1_im(i_rx1_im),
        .i_rx2_re(i_rx2_re), .i_rx2_im(i_rx2_im),
        .o_valid(buf_valid), .o_drop(buf_drop),
        .o_rx1_re(buf_rx1_re), .o_rx1_im(buf_rx1_im),
        .o_rx2_re(buf_rx2_re), .o_rx2_im(buf_rx2_im)
    );

    // Inverse channel registers and drop count
    rx_csr u_csr (
        .clk(clk), .rst_n(rst_n),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .i_drop(buf_drop),
        .o_h00_re(h00_re), .o_h00_im(h00_im), .o_h01_re(h01_re), .o_h01_im(h01_im),
        .o_h10_re(h10_re), .o_h10_im(h10_im), .o_h11_re(h11_re), .o_h11_im(h11_im)
    );

    // ZF equalizer and slicer
    zf_qpsk_detector u_det (
        .clk(clk), .rst_n(rst_n),
        .i_valid(buf_valid),
        .i_y1_re(buf_rx1_re), .i_y1_im(buf_rx1_im),
        .i_y2_re(buf_rx2_re), .i_y2_im(buf_rx2_im),
        .i_h00_re(h00_re), .i_h00_im(h00_im), .i_h01_re(h01_re), .i_h01_im(h01_im),
        .i_h10_re(h10_re), .i_h10_im(h10_im), .i_h11_re(h11_re), .i_h11_im(h11_im),
        .o_valid(o_valid), .o_bits(o_rx_bits)
    );

endmodule

// File: design/zf_qpsk_detector.sv
`timescale 1ns/1ps

module zf_qpsk_detector (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 i_valid,
    input  mimo_rx_pkg::sample_t i_y1_re,
    input  mimo_rx_pkg::sample_t i_y1_im,
    input  mimo_rx_pkg::sample_t i_y2_re,
    input  mimo_rx_pkg::sample_t i_y2_im,

    input  mimo_rx_pkg::coef_t   i_h00_re,
    input  mimo_rx_pkg::coef_t   i_h00_im,
    input  mimo_rx_pkg::coef_t   i_h01_re,
    input  mimo_rx_pkg::coef_t   i_h01_im,
    input  mimo_rx_pkg::coef_t   i_h10_re,
    input  mimo_rx_pkg::coef_t   i_h10_im,
    input  mimo_rx_pkg::coef_t   i_h11_re,
    input  mimo_rx_pkg::coef_t   i_h11_im,

    output logic                 o_valid,
    output mimo_rx_pkg::bits_t   o_bits
);

    // Complex product part and sum of two of them, no rounding loss
    typedef logic signed [2*mimo_rx_pkg::DATA_W:0]   prod_t;
    typedef logic signed [2*mimo_rx_pkg::DATA_W+1:0] acc_t;

    // Real part of h*y
    function automatic prod_t cmul_re(input mimo_rx_pkg::coef_t   h_re,
                                      input mimo_rx_pkg::coef_t   h_im,
                                      input mimo_rx_pkg::sample_t y_re,
                                      input mimo_rx_pkg::sample_t y_im);
        prod_t p_rr;
        prod_t p_ii;
        p_rr = h_re * y_re;
        p_ii = h_im * y_im;
        return p_rr - p_ii;
    endfunction

    // Imaginary part of h*y
    function automatic prod_t cmul_im(input mimo_rx_pkg::coef_t   h_re,
                                      input mimo_rx_pkg::coef_t   h_im,
                                      input mimo_rx_pkg::sample_t y_re,
                                      input mimo_rx_pkg::sample_t y_im);
        prod_t p_ri;
        prod_t p_ir;
        p_ri = h_re * y_im;
        p_ir = h_im * y_re;
        return p_ri + p_ir;
    endfunction

    // Add, drop Q2.13 fraction by truncation, clamp to sample range
    function automatic mimo_rx_pkg::sample_t sum_sat(input prod_t a, input prod_t b);
        acc_t s;
        s = a + b;
        s = s >>> mimo_rx_pkg::COEF_FRAC;
        if (s > acc_t'(2**(mimo_rx_pkg::DATA_W-1) - 1)) begin
            return {1'b0, {(mimo_rx_pkg::DATA_W-1){1'b1}}};
        end else if (s < acc_t'(-(2**(mimo_rx_pkg::DATA_W-1)))) begin
            return {1'b1, {(mimo_rx_pkg::DATA_W-1){1'b0}}};
        end
        return mimo_rx_pkg::sample_t'(s);
    endfunction

    // Stage 1 products
    prod_t p1a_re, p1a_im, p1b_re, p1b_im;  // h00*y1, h01*y2
    prod_t p2a_re, p2a_im, p2b_re, p2b_im;  // h10*y1, h11*y2
    logic  v1_q;

    // Stage 2 equalized samples
    mimo_rx_pkg::sample_t x1_re_q, x1_im_q, x2_re_q, x2_im_q;
    logic                 v2_q;

    // ======================================================================
    // Datapath
    // ======================================================================
    always_ff @(posedge clk) begin
        p1a_re <= cmul_re(i_h00_re, i_h00_im, i_y1_re, i_y1_im);
        p1a_im <= cmul_im(i_h00_re, i_h00_im, i_y1_re, i_y1_im);
        p1b_re <= cmul_re(i_h01_re, i_h01_im, i_y2_re, i_y2_im);
        p1b_im <= cmul_im(i_h01_re, i_h01_im, i_y2_re, i_y2_im);
        p2a_re <= cmul_re(i_h10_re, i_h10_im, i_y1_re, i_y1_im);
        p2a_im <= cmul_im(i_h10_re, i_h10_im, i_y1_re, i_y1_im);
        p2b_re <= cmul_re(i_h11_re, i_h11_im, i_y2_re, i_y2_im);
        p2b_im <= cmul_im(i_h11_re, i_h11_im, i_y2_re, i_y2_im);

        x1_re_q <= sum_sat(p1a_re, p1b_re);
        x1_im_q <= sum_sat(p1a_im, p1b_im);
        x2_re_q <= sum_sat(p2a_re, p2b_re);
        x2_im_q <= sum_sat(p2a_im, p2b_im);

        // QPSK hard decision, negative maps to 1
        o_bits <= {x2_im_q[mimo_rx_pkg::DATA_W-1], x2_re_q[mimo_rx_pkg::DATA_W-1],
                   x1_im_q[mimo_rx_pkg::DATA_W-1], x1_re_q[mimo_rx_pkg::DATA_W-1]};
    end

    // Valid follows the three register stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q    <= 1'b0;
            v2_q    <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            v1_q    <= i_valid;
            v2_q    <= v1_q;
            o_valid <= v2_q;
        end
    end

endmodule

// File: design/rx_csr.sv
`timescale 1ns/1ps

module rx_csr (
    input  logic                   clk,
    input  logic                   rst_n,

    // APB slave
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  mimo_rx_pkg::apb_addr_t i_paddr,
    input  mimo_rx_pkg::apb_data_t i_pwdata,
    output mimo_rx_pkg::apb_data_t o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,

    input  logic                   i_drop,

    output mimo_rx_pkg::coef_t     o_h00_re,
    output mimo_rx_pkg::coef_t     o_h00_im,
    output mimo_rx_pkg::coef_t     o_h01_re,
    output mimo_rx_pkg::coef_t     o_h01_im,
    output mimo_rx_pkg::coef_t     o_h10_re,
    output mimo_rx_pkg::coef_t     o_h10_im,
    output mimo_rx_pkg::coef_t     o_h11_re,
    output mimo_rx_pkg::coef_t     o_h11_im
);

    mimo_rx_pkg::coef_t     coef_q [8];     // Ordered as the register map
    mimo_rx_pkg::drop_cnt_t drop_cnt_q;

    logic       access;
    logic       addr_err;
    logic       is_cnt;
    logic [2:0] coef_sel;

    assign access   = i_psel && i_penable;
    assign addr_err = (i_paddr > mimo_rx_pkg::REG_DROP_CNT);
    assign is_cnt   = (i_paddr >= mimo_rx_pkg::REG_DROP_CNT) && !addr_err;
    assign coef_sel = i_paddr[4:2];         // Word index inside coefficient window

    assign o_pready  = 1'b1;                // No wait states
    assign o_pslverr = access && (addr_err || (i_pwrite && is_cnt));

    // Read mux, coefficients sign-extended
    always_comb begin
        o_prdata = '0;
        if (is_cnt) begin
            o_prdata = {16'd0, drop_cnt_q};
        end else if (!addr_err) begin
            o_prdata = {{(32 - mimo_rx_pkg::DATA_W){coef_q[coef_sel][mimo_rx_pkg::DATA_W-1]}},
                        coef_q[coef_sel]};
        end
    end

    // ======================================================================
    // Coefficient registers, identity after reset
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                coef_q[i] <= '0;
            end
            coef_q[mimo_rx_pkg::REG_H00_RE[4:2]] <= mimo_rx_pkg::COEF_ONE;
            coef_q[mimo_rx_pkg::REG_H11_RE[4:2]] <= mimo_rx_pkg::COEF_ONE;
        end else if (access && i_pwrite && !addr_err && !is_cnt) begin
            coef_q[coef_sel] <= i_pwdata[mimo_rx_pkg::DATA_W-1:0];
        end
    end

    // Saturating drop counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt_q <= '0;
        end else if (i_drop && (drop_cnt_q != '1)) begin
            drop_cnt_q <= drop_cnt_q + 1'b1;
        end
    end

    assign o_h00_re = coef_q[mimo_rx_pkg::REG_H00_RE[4:2]];
    assign o_h00_im = coef_q[mimo_rx_pkg::REG_H00_IM[4:2]];
    assign o_h01_re = coef_q[mimo_rx_pkg::REG_H01_RE[4:2]];
    assign o_h01_im = coef_q[mimo_rx_pkg::REG_H01_IM[4:2]];
    assign o_h10_re = coef_q[mimo_rx_pkg::REG_H10_RE[4:2]];
    assign o_h10_im = coef_q[mimo_rx_pkg::REG_H10_IM[4:2]];
    assign o_h11_re = coef_q[mimo_rx_pkg::REG_H11_RE[4:2]];
    assign o_h11_im = coef_q[mimo_rx_pkg::REG_H11_IM[4:2]];

endmodule

// File: design/symbol_buffer.sv
`timescale 1ns/1ps

module symbol_buffer (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 i_valid,
    input  logic                 i_symbol_start,
    input  mimo_rx_pkg::sample_t i_rx1_re,
    input  mimo_rx_pkg::sample_t i_rx1_im,
    input  mimo_rx_pkg::sample_t i_rx2_re,
    input  mimo_rx_pkg::sample_t i_rx2_im,

    output logic                 o_valid,
    output logic                 o_drop,
    output mimo_rx_pkg::sample_t o_rx1_re,
    output mimo_rx_pkg::sample_t o_rx1_im,
    output mimo_rx_pkg::sample_t o_rx2_re,
    output mimo_rx_pkg::sample_t o_rx2_im
);

    localparam mimo_rx_pkg::buf_idx_t LAST_IDX  = mimo_rx_pkg::buf_idx_t'(mimo_rx_pkg::SYM_LEN - 1);
    localparam mimo_rx_pkg::buf_idx_t FIRST_RD = mimo_rx_pkg::buf_idx_t'(mimo_rx_pkg::NCP);

    mimo_rx_pkg::buf_state_t state_q;
    mimo_rx_pkg::buf_idx_t   wr_idx_q;      // Next capture slot
    mimo_rx_pkg::buf_idx_t   rd_idx_q;      // Next replay slot
    mimo_rx_pkg::buf_idx_t   rd_addr_q;
    logic                    rd_en_q;

    logic                    start_ok;
    logic                    wr_en;
    mimo_rx_pkg::buf_idx_t   wr_addr;

    // One 80-entry store per component
    mimo_rx_pkg::sample_t mem_rx1_re [mimo_rx_pkg::SYM_LEN];
    mimo_rx_pkg::sample_t mem_rx1_im [mimo_rx_pkg::SYM_LEN];
    mimo_rx_pkg::sample_t mem_rx2_re [mimo_rx_pkg::SYM_LEN];
    mimo_rx_pkg::sample_t mem_rx2_im [mimo_rx_pkg::SYM_LEN];

    // A start seen during replay is not accepted
    assign start_ok = i_valid && i_symbol_start && (state_q != mimo_rx_pkg::BUF_REPLAY);
    assign wr_en    = start_ok || (i_valid && (state_q == mimo_rx_pkg::BUF_CAPTURE));
    assign wr_addr  = start_ok ? '0 : wr_idx_q;

    // ======================================================================
    // Capture / replay control
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= mimo_rx_pkg::BUF_IDLE;
            wr_idx_q  <= '0;
            rd_idx_q  <= '0;
            rd_addr_q <= '0;
            rd_en_q   <= 1'b0;
            o_drop    <= 1'b0;
            o_valid   <= 1'b0;
        end else begin
            rd_en_q <= 1'b0;
            o_valid <= rd_en_q;                 // Data lands one cycle after address
            o_drop  <= i_valid && i_symbol_start && (state_q == mimo_rx_pkg::BUF_REPLAY);

            case (state_q)
                mimo_rx_pkg::BUF_IDLE: begin
                    if (start_ok) begin
                        wr_idx_q <= 7'd1;       // Index 0 written this cycle
                        state_q  <= mimo_rx_pkg::BUF_CAPTURE;
                    end
                end

                mimo_rx_pkg::BUF_CAPTURE: begin
                    if (start_ok) begin
                        wr_idx_q <= 7'd1;       // Fresh start restarts the symbol
                    end else if (i_valid) begin
                        if (wr_idx_q == LAST_IDX) begin
                            rd_idx_q <= FIRST_RD;   // Skip the CP on replay
                            state_q  <= mimo_rx_pkg::BUF_REPLAY;
                        end else begin
                            wr_idx_q <= wr_idx_q + 1'b1;
                        end
                    end
                end

                mimo_rx_pkg::BUF_REPLAY: begin
                    rd_en_q   <= 1'b1;
                    rd_addr_q <= rd_idx_q;
                    if (rd_idx_q == LAST_IDX) begin
                        state_q <= mimo_rx_pkg::BUF_IDLE;
                    end else begin
                        rd_idx_q <= rd_idx_q + 1'b1;
                    end
                end

                default: state_q <= mimo_rx_pkg::BUF_IDLE;
            endcase
        end
    end

    // ======================================================================
    // Sample storage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_rx1_re[wr_addr] <= i_rx1_re;
            mem_rx1_im[wr_addr] <= i_rx1_im;
            mem_rx2_re[wr_addr] <= i_rx2_re;
            mem_rx2_im[wr_addr] <= i_rx2_im;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            o_rx1_re <= mem_rx1_re[rd_addr_q];
            o_rx1_im <= mem_rx1_im[rd_addr_q];
            o_rx2_re <= mem_rx2_re[rd_addr_q];
            o_rx2_im <= mem_rx2_im[rd_addr_q];
        end
    end

endmodule

// File: design/mimo_rx_pkg.sv
package mimo_rx_pkg;

    // ======================================================================
    // Widths and basic types
    // ======================================================================
    localparam int DATA_W = 16;

    typedef logic signed [DATA_W-1:0] sample_t;   // One I or Q component
    typedef logic signed [DATA_W-1:0] coef_t;     // Q2.13 inverse-channel entry

    localparam int    COEF_FRAC = 13;
    localparam coef_t COEF_ONE  = coef_t'(8192);  // 1.0 in Q2.13

    // ======================================================================
    // Symbol geometry
    // ======================================================================
    localparam int NCP     = 16;                  // Cyclic prefix
    localparam int NFFT    = 64;                  // Data samples per symbol
    localparam int SYM_LEN = NCP + NFFT;          // 80 samples captured

    typedef logic [6:0] buf_idx_t;
    typedef logic [3:0] bits_t;                   // {x2_im, x2_re, x1_im, x1_re}

    // ======================================================================
    // APB register map
    // ======================================================================
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [15:0] drop_cnt_t;

    localparam apb_addr_t REG_H00_RE   = 8'h00;
    localparam apb_addr_t REG_H00_IM   = 8'h04;
    localparam apb_addr_t REG_H01_RE   = 8'h08;
    localparam apb_addr_t REG_H01_IM   = 8'h0C;
    localparam apb_addr_t REG_H10_RE   = 8'h10;
    localparam apb_addr_t REG_H10_IM   = 8'h14;
    localparam apb_addr_t REG_H11_RE   = 8'h18;
    localparam apb_addr_t REG_H11_IM   = 8'h1C;
    localparam apb_addr_t REG_DROP_CNT = 8'h20;   // Read only

    // Symbol buffer FSM
    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_CAPTURE,
        BUF_REPLAY
    } buf_state_t;

endpackage
